/* src.f */
source/nocPkg.sv
source/flitInputPort.sv
source/packetTimer.sv
source/linkArbiter.sv
source/flitOutputPort.sv
source/linkMux.sv
testbench/linkMux_assert.sv
testbench/linkMuxTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = linkMuxTb
FILELIST = src.f
BUILD    = obj_dir
LOG      = run.log
PASS     = Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/linkMuxTb.sv */
module linkMuxTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BufferDepth = 4;
  localparam int PacketsPerPort = 16;   // Most packets one port sends over all phases
  localparam int MaxFlits = nocPkg::NumPorts * PacketsPerPort * 7;
  localparam int TimeoutCycles = MaxFlits * 40;
  localparam logic [31:0] Seed = 32'h95a1_1342;

  logic             clk;
  logic             rst;
  nocPkg::portVec_t inReq;
  nocPkg::portVec_t inAck;
  nocPkg::flit_t    inFlit [nocPkg::NumPorts];
  logic             outReq;
  logic             outAck;
  nocPkg::flit_t    outFlit;

  nocPkg::flit_t txQ [nocPkg::NumPorts][$];    // Still to be sent
  nocPkg::flit_t sentQ [nocPkg::NumPorts][$];  // Sent but not yet delivered

  logic [31:0] rngPkt = Seed;
  logic [31:0] rngStall = ~Seed;
  string testName = "reset";
  bit stallOn;
  bit checkRotation;
  int stallLeft;
  int remaining = -1;   // Flits left in the current packet or -1 between packets
  int curTag;
  int lastPort;
  int flitCount;
  int packetCount;
  int errorCount;

  linkMux
  #(
    .BufferDepth (BufferDepth)
  )
  i_linkMux
  (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inAck   (inAck),
    .inFlit  (inFlit),
    .outReq  (outReq),
    .outAck  (outAck),
    .outFlit (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic int randBelow(int n);
    rngPkt = xorshift(rngPkt);
    return int'(rngPkt % 32'(n));
  endfunction

  // Each port's packets leave in the order they were sent
  function automatic nocPkg::flit_t expectedFlit(int tag);
    return sentQ[tag][0];
  endfunction

  // Owner after a release when every port has a packet waiting
  function automatic int nextOwner(int last);
    return (last + 1) % nocPkg::NumPorts;
  endfunction

  task automatic queuePacket(int port, int length);
    nocPkg::flit_t f;
    f.kind = nocPkg::Head;
    f.payload.header.sourceTag = 4'(port);
    f.payload.header.length = 12'(length);
    txQ[port].push_back(f);
    sentQ[port].push_back(f);
    for (int i = 1; i <= length; i++)
    begin
      rngPkt = xorshift(rngPkt);
      if (i == length)
        f.kind = nocPkg::Tail;
      else
        f.kind = nocPkg::Body;
      f.payload.data = rngPkt[15:0];
      txQ[port].push_back(f);
      sentQ[port].push_back(f);
    end
  endtask

  task automatic waitDrained();
    int pending;
    do
    begin
      @(posedge clk);
      pending = 0;
      for (int p = 0; p < nocPkg::NumPorts; p++)
        pending += sentQ[p].size();
    end
    while (pending != 0);
    repeat (8) @(posedge clk);   // Let the last handshake settle
  endtask

  task automatic checkFlit(nocPkg::flit_t got);
    nocPkg::flit_t exp;
    int tag;
    bit known;
    flitCount++;
    if (remaining < 0)
    begin
      tag = int'(got.payload.header.sourceTag);
      known = 1'b0;
      if (got.kind == nocPkg::Head && tag < nocPkg::NumPorts)
        known = sentQ[tag].size() != 0;
      assert (known)
      else
      begin
        errorCount++;
        $display("%s: flit %h arrived where no packet header was expected", testName, got);
      end
      if (!known)
        return;
      packetCount++;
      if (checkRotation)
      begin
        assert (tag == nextOwner(lastPort))
        else
        begin
          errorCount++;
          $display("Fail %s: expected port %0d, actual port %0d", testName,
                   nextOwner(lastPort), tag);
        end
      end
      lastPort = tag;
      curTag = tag;
    end
    else
    begin
      assert (sentQ[curTag].size() != 0)
      else
      begin
        errorCount++;
        $display("%s: extra flit %h from port %0d after its packets ended", testName, got,
                 curTag);
      end
      if (sentQ[curTag].size() == 0)
      begin
        remaining = -1;
        return;
      end
    end
    exp = expectedFlit(curTag);
    sentQ[curTag].delete(0);
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("Fail %s: expected %h, actual %h", testName, exp, got);
    end
    if (remaining < 0)
      remaining = int'(exp.payload.header.length);
    else
      remaining--;
    if (remaining == 0)
      remaining = -1;
  endtask

  // One sender per input channel
  for (genvar p = 0; p < nocPkg::NumPorts; p++)
  begin : g_sender
    initial
    begin
      nocPkg::flit_t f;
      forever
      begin
        @(posedge clk);
        if (!rst && txQ[p].size() != 0)
        begin
          f = txQ[p].pop_front();
          inFlit[p] <= f;
          inReq[p] <= 1'b1;
          @(posedge clk);
          while (!inAck[p])
            @(posedge clk);
          inReq[p] <= 1'b0;
          @(posedge clk);
          while (inAck[p])
            @(posedge clk);
        end
      end
    end
  end

  // Output side receiver and checker
  initial
  begin
    outAck = 1'b0;
    forever
    begin
      @(posedge clk);
      if (outReq && !outAck)
      begin
        if (stallLeft > 0)
          stallLeft--;
        else
        begin
          checkFlit(outFlit);
          outAck <= 1'b1;
          if (stallOn)
          begin
            rngStall = xorshift(rngStall);
            stallLeft = int'(rngStall % 32'd8);
          end
        end
      end
      else if (!outReq && outAck)
        outAck <= 1'b0;
    end
  end

  initial
  begin
    int count;
    rst = 1'b1;
    inReq = '0;
    for (int p = 0; p < nocPkg::NumPorts; p++)
      inFlit[p] = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    testName = "single port";
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      @(negedge clk);   // Queues filled between edges so all senders start together
      for (int k = 0; k < 3; k++)
        queuePacket(p, randBelow(7));
      waitDrained();
    end

    @(negedge clk);
    testName = "integrity";
    stallOn = 1'b1;
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      count = 2 + randBelow(5);
      for (int k = 0; k < count; k++)
        queuePacket(p, randBelow(7));
    end
    waitDrained();

    @(negedge clk);
    testName = "rotation";
    checkRotation = 1'b1;
    lastPort = nocPkg::PortS;   // First packet from idle goes to L
    for (int k = 0; k < 4; k++)
      for (int p = 0; p < nocPkg::NumPorts; p++)
        queuePacket(p, randBelow(7));
    waitDrained();

    @(negedge clk);
    testName = "zero length";
    lastPort = nocPkg::PortS;
    for (int k = 0; k < 3; k++)
      for (int p = 0; p < nocPkg::NumPorts; p++)
        queuePacket(p, 0);
    waitDrained();

    $display("Flits checked: %0d, packets: %0d, errors: %0d", flitCount, packetCount,
             errorCount);
    if (errorCount == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout after %0d cycles in %s, flits never reached the output", TimeoutCycles,
             testName);
    $display("Flits checked: %0d, packets: %0d, errors: %0d", flitCount, packetCount,
             errorCount);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* testbench/linkMux_assert.sv */
module linkMuxAssert
(
  input logic             clk,
  input logic             rst,
  input nocPkg::portVec_t grant,
  input nocPkg::portVec_t pop,
  input logic             req,
  input logic             ack
);

  timeunit 1ns;
  timeprecision 100ps;

  // At most one owner of the output link
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("Grant holds more than one port: %b", grant);

  // Owner keeps the link until a transfer of its own ends the packet
  grantEndsOnPop: assert property (@(posedge clk) disable iff (rst)
    ($past(grant) != '0 && grant != $past(grant)) |-> $past(pop) == $past(grant))
    else $error("Grant moved to %b without a transfer from the previous owner", grant);

  ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else $error("Input ack rose without a request");

  ackFallsAfterReq: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
    else $error("Input ack fell while the request was still high");

endmodule

// Grant checks on the arbiter with handshake inputs tied low
bind linkArbiter linkMuxAssert i_arbiterAssert
(
  .clk   (clk),
  .rst   (rst),
  .grant (grant),
  .pop   (pop),
  .req   (1'b0),
  .ack   (1'b0)
);

// Handshake checks on every receiver
bind flitInputPort linkMuxAssert i_inputAssert
(
  .clk   (clk),
  .rst   (rst),
  .grant ('0),
  .pop   ('0),
  .req   (inReq),
  .ack   (inAck)
);

/* source/linkMux.sv */
module linkMux
#(
  parameter int BufferDepth = 4
)
(
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::portVec_t inReq,
  output nocPkg::portVec_t inAck,
  input  nocPkg::flit_t    inFlit [nocPkg::NumPorts],
  output logic             outReq,
  input  logic             outAck,
  output nocPkg::flit_t    outFlit
);

  nocPkg::portVec_t headValid;
  nocPkg::flit_t    headFlit [nocPkg::NumPorts];
  nocPkg::portVec_t pop;
  nocPkg::flit_t    selFlit;
  logic             load;
  logic             ready;

  // One receiver and queue per channel, L N E W S
  for (genvar p = 0; p < nocPkg::NumPorts; p++)
  begin : g_input
    flitInputPort
    #(
      .BufferDepth (BufferDepth)
    )
    i_flitInputPort
    (
      .clk       (clk),
      .rst       (rst),
      .inReq     (inReq[p]),
      .inFlit    (inFlit[p]),
      .inAck     (inAck[p]),
      .pop       (pop[p]),
      .headValid (headValid[p]),
      .headFlit  (headFlit[p])
    );
  end

  linkArbiter i_linkArbiter
  (
    .clk       (clk),
    .rst       (rst),
    .headValid (headValid),
    .headFlit  (headFlit),
    .ready     (ready),
    .grant     (),
    .pop       (pop),
    .selFlit   (selFlit),
    .load      (load)
  );

  flitOutputPort i_flitOutputPort
  (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .selFlit (selFlit),
    .ready   (ready),
    .outReq  (outReq),
    .outFlit (outFlit),
    .outAck  (outAck)
  );

endmodule

/* source/flitOutputPort.sv */
module flitOutputPort
(
  input  logic          clk,
  input  logic          rst,
  input  logic          load,
  input  nocPkg::flit_t selFlit,
  output logic          ready,
  output logic          outReq,
  output nocPkg::flit_t outFlit,
  input  logic          outAck
);

  typedef enum logic [1:0]
  {
    Empty      = 2'd0,
    Requesting = 2'd1,
    WaitAckLow = 2'd2
  } sendState_t;

  sendState_t state;

  assign ready = (state == Empty);
  assign outReq = (state == Requesting);  // Flit held stable meanwhile

  always_ff @(posedge clk)
  begin
    if (load && ready)
      outFlit <= selFlit;
  end

  // Sender side of the four-phase link
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Empty;
    else
    begin
      case (state)
        Empty:
        begin
          if (load)
            state <= Requesting;
        end
        Requesting:
        begin
          if (outAck)
            state <= WaitAckLow;
        end
        WaitAckLow:
        begin
          if (!outAck)
            state <= Empty;   // Ready again
        end
        default:
        begin
          state <= Empty;
        end
      endcase
    end
  end

endmodule

/* source/linkArbiter.sv */
module linkArbiter
(
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::portVec_t headValid,
  input  nocPkg::flit_t    headFlit [nocPkg::NumPorts],
  input  logic             ready,
  output nocPkg::portVec_t grant,
  output nocPkg::portVec_t pop,
  output nocPkg::flit_t    selFlit,
  output logic             load
);

  nocPkg::grantState_t state;
  nocPkg::grantState_t nextState;
  nocPkg::portVec_t    timesUp;

  // First requester in rotation from start, idle if none
  function automatic nocPkg::grantState_t pickNext(nocPkg::portVec_t req, int start);
    nocPkg::grantState_t pick;
    int idx;
    pick = nocPkg::IdleState;
    // Walk backwards so the closest port wins
    for (int k = nocPkg::NumPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % nocPkg::NumPorts;
      if (req[idx])
      begin
        pick = '0;
        pick[idx + 1] = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < nocPkg::NumPorts; p++)
  begin : g_timer
    packetTimer i_packetTimer
    (
      .clk     (clk),
      .rst     (rst),
      .flit    (headFlit[p]),
      .move    (pop[p]),
      .timesUp (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::IdleState;
    else
      state <= nextState;
  end

  assign grant = state[nocPkg::NumPorts:1];

  // A transfer needs the owner's head flit and an empty output register
  assign pop = grant & headValid & {nocPkg::NumPorts{ready}};
  assign load = |pop;

  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      if (grant[p])
        selFlit = headFlit[p];
    end
  end

  always_comb
  begin
    nextState = state;
    if (state[0])
      nextState = pickNext(headValid, nocPkg::PortL);  // Fixed order from idle
    else
    begin
      for (int p = 0; p < nocPkg::NumPorts; p++)
      begin
        // Releasing port is left out, its headValid may refer to the
        // flit being popped right now
        if (state[p + 1] && timesUp[p])
          nextState = pickNext(headValid & ~nocPkg::portVec_t'(1 << p),
                               (p + 1) % nocPkg::NumPorts);
      end
    end
  end

endmodule

/* source/packetTimer.sv */
module packetTimer
(
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t flit,
  input  logic          move,
  output logic          timesUp
);

  logic [11:0] pktLength;
  logic [11:0] flitCount;   // Flits moved since the header
  logic        isHead;
  logic        lastFlit;

  assign isHead = (flit.kind == nocPkg::Head);

  // Header of length zero is a packet on its own
  always_comb
  begin
    if (isHead)
      lastFlit = (flit.payload.header.length == 12'd0);
    else
      lastFlit = (flitCount + 12'd1 == pktLength);
  end

  assign timesUp = move && lastFlit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLength <= '0;
      flitCount <= '0;
    end
    else if (move)
    begin
      if (isHead)
      begin
        pktLength <= flit.payload.header.length;
        flitCount <= '0;
      end
      else
        flitCount <= flitCount + 12'd1;
    end
  end

endmodule

/* source/flitInputPort.sv */
module flitInputPort
#(
  parameter int BufferDepth = 4
)
(
  input  logic          clk,
  input  logic          rst,
  input  logic          inReq,
  input  nocPkg::flit_t inFlit,
  output logic          inAck,
  input  logic          pop,
  output logic          headValid,
  output nocPkg::flit_t headFlit
);

  localparam int PtrW = (BufferDepth > 1) ? $clog2(BufferDepth) : 1;
  localparam int CntW = $clog2(BufferDepth + 1);

  nocPkg::flit_t queue [BufferDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic full;
  logic push;

  function automatic logic [PtrW-1:0] advance(logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(BufferDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full = (count == CntW'(BufferDepth));
  assign push = inReq && !inAck && !full;  // Ack withheld while full

  assign headValid = (count != '0);
  assign headFlit = queue[rdPtr];

  // Receiver side of the four-phase link
  always_ff @(posedge clk)
  begin
    if (rst)
      inAck <= 1'b0;
    else if (push)
      inAck <= 1'b1;
    else if (inAck && !inReq)
      inAck <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (push)
      queue[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= advance(wrPtr);
      if (pop)
        rdPtr <= advance(rdPtr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

/* source/nocPkg.sv */
package nocPkg;

  typedef enum logic [2:0]
  {
    Head = 3'b001,
    Body = 3'b010,
    Tail = 3'b100
  } flitKind_t;

  // Payload as seen in a header flit
  typedef struct packed
  {
    logic [3:0]  sourceTag;
    logic [11:0] length;    // Flits that follow the header
  } headerView_t;

  typedef union packed
  {
    headerView_t header;
    logic [15:0] data;      // Body and tail flits
  } payload_t;

  typedef struct packed
  {
    flitKind_t kind;
    payload_t  payload;
  } flit_t;

  localparam int NumPorts = 5;

  // Port indices, also the idle priority order
  localparam int PortL = 0;
  localparam int PortN = 1;
  localparam int PortE = 2;
  localparam int PortW = 3;
  localparam int PortS = 4;

  typedef logic [NumPorts-1:0] portVec_t;

  // Bit 0 idle, bit p+1 means port p owns the link
  typedef logic [NumPorts:0] grantState_t;

  localparam grantState_t IdleState = grantState_t'(1);

endpackage
